// ==== hdl/player_cfg.svh ====
`ifndef PLAYER_CFG_SVH
`define PLAYER_CFG_SVH

// ============================================================
// Player start position and sprite extent
// ============================================================
`define PLAYER_X_START 12'd32
`define PLAYER_Y_START 12'd388
`define PLAYER_SIZE 12'd32

// ============================================================
// Screen limits
// ============================================================
// Left edge of the walkable area
`define X_MIN 12'd0
// Right limit, narrow or wide screen
`define X_MAX_NARROW 12'd319
`define X_MAX_WIDE 12'd639
// Bottom of sprite at or past this line snaps back to start
`define GROUND_LINE 12'd421

// Pixels per horizontal move and per scroll step
`define WALK_STEP 12'd3
`define SCROLL_STEP 12'd3

// Keyboard usage codes
`define KEY_LEFT 8'h04
`define KEY_RIGHT 8'h07
`define KEY_JUMP 8'h1A

// Two pipes, four bricks, one stair
`define OBSTACLE_COUNT 7

// ============================================================
// Frame counter wrap and step divisors
// ============================================================
`define TICK_WRAP 1000
`define WALK_DIV 5
`define JUMP_DIV 2

`endif

// ==== hdl/player_pkg.sv ====
`include "player_cfg.svh"

package player_pkg;

	// Screen position, unsigned pixels
	typedef logic [11:0] coordT;
	// Raw keyboard usage code
	typedef logic [7:0] keycodeT;
	// One contact bit per obstacle
	typedef logic [`OBSTACLE_COUNT-1:0] obstacleMaskT;
	// Vertical pixels per frame, negative is up
	typedef logic signed [11:0] velocityT;

	// Walking pose FSM
	typedef enum logic [3:0] {
		Idle,
		LeftFootLeft, Switch1Left, RightFootLeft, Switch2Left,
		LeftFootRight, Switch1Right, RightFootRight, Switch2Right
	} walkStateT;

	// Jump arc and fall FSM, states kept in sequence order
	typedef enum logic [5:0] {
		Start, Jump1, JumpA,
		Jump2, Jump3, Jump4, Jump5, Jump6, Jump7, Jump8, Jump9, Jump10,
		ArcTop,
		Fall0, Fall1, Fall2, Fall3, Fall4, Fall5, Fall6, Fall7,
		Fall8, Fall9, Fall10, Fall11, Fall12, Fall13, Fall14, Fall15
	} jumpStateT;

endpackage

// ==== hdl/frameTicker.sv ====
`include "player_cfg.svh"

module frameTicker (
	input  logic Reset,
	input  logic frame_clk,
	output logic walkTick,
	output logic jumpTick
);

	// Counter just wide enough to hold the wrap value
	localparam int TickWidth = $clog2(`TICK_WRAP + 1);
	localparam logic [TickWidth-1:0] TickLast = TickWidth'(`TICK_WRAP);

	logic [TickWidth-1:0] tickCount;

	// Free running, wraps after the last count
	always_ff @(posedge frame_clk or posedge Reset) begin
		if (Reset)
			tickCount <= '0;
		else if (tickCount >= TickLast)
			tickCount <= '0;
		else
			tickCount <= tickCount + 1'b1;
	end

	// Strobes on multiples of each divisor, both high at count 0
	assign walkTick = (tickCount % TickWidth'(`WALK_DIV)) == '0;
	assign jumpTick = (tickCount % TickWidth'(`JUMP_DIV)) == '0;

	// Count stays inside its range
	tickRange: assert property (@(posedge frame_clk) disable iff (Reset)
		tickCount <= TickLast)
		else $error("frame counter above wrap value");

endmodule

// ==== hdl/walkAnimator.sv ====
`include "player_cfg.svh"

module walkAnimator
	import player_pkg::*;
(
	input  logic    Reset,
	input  logic    frame_clk,
	input  logic    walkTick,
	input  logic    facingRight,
	input  keycodeT keycode,
	output logic [3:0] walkPose
);

	walkStateT walkState;
	walkStateT walkNext;

	// Pose fields, packed as {direction, switch, right foot, left foot}
	logic poseDir;
	logic poseSwitch;
	logic poseRight;
	logic poseLeft;

	logic holdLeft;
	logic holdRight;

	// Only the first key slot drives the animation
	assign holdLeft = keycode == `KEY_LEFT;
	assign holdRight = keycode == `KEY_RIGHT;

	// ============================================================
	// State register, advances on walk strobe only
	// ============================================================
	always_ff @(posedge frame_clk or posedge Reset) begin
		if (Reset)
			walkState <= Idle;
		else if (walkTick)
			walkState <= walkNext;
	end

	// Next state
	always_comb begin
		walkNext = walkState;
		case (walkState)
			Idle: begin
				// Start a cycle only toward the current facing
				if (!facingRight && holdLeft)
					walkNext = LeftFootLeft;
				else if (facingRight && holdRight)
					walkNext = LeftFootRight;
			end
			// Left walk loop
			LeftFootLeft:   walkNext = holdLeft ? Switch1Left : Idle;
			Switch1Left:    walkNext = holdLeft ? RightFootLeft : Idle;
			RightFootLeft:  walkNext = holdLeft ? Switch2Left : Idle;
			Switch2Left:    walkNext = holdLeft ? LeftFootLeft : Idle;
			// Right walk loop
			LeftFootRight:  walkNext = holdRight ? Switch1Right : Idle;
			Switch1Right:   walkNext = holdRight ? RightFootRight : Idle;
			RightFootRight: walkNext = holdRight ? Switch2Right : Idle;
			Switch2Right:   walkNext = holdRight ? LeftFootRight : Idle;
			default:        walkNext = Idle;
		endcase
	end

	// ============================================================
	// Pose decode
	// ============================================================
	always_comb begin
		poseDir = 1'b0;
		poseSwitch = 1'b0;
		poseRight = 1'b0;
		poseLeft = 1'b0;
		case (walkState)
			// Standing pose keeps the facing
			Idle:           poseDir = facingRight;
			LeftFootLeft:   poseLeft = 1'b1;
			Switch1Left,
			Switch2Left:    poseSwitch = 1'b1;
			// Sprite table shows this frame with direction set
			RightFootLeft:  poseDir = 1'b1;
			LeftFootRight: begin
				poseDir = 1'b1;
				poseLeft = 1'b1;
			end
			Switch1Right,
			Switch2Right: begin
				poseDir = 1'b1;
				poseSwitch = 1'b1;
			end
			RightFootRight: begin
				poseDir = 1'b1;
				poseRight = 1'b1;
			end
			default:        poseDir = facingRight;
		endcase
	end

	assign walkPose = {poseDir, poseSwitch, poseRight, poseLeft};

	// Pose only moves on the frame ticker's walk strobe
	walkOnTick: assert property (@(posedge frame_clk) disable iff (Reset)
		!walkTick |=> $stable(walkState))
		else $error("walk state changed without a walk tick");

endmodule

// ==== hdl/jumpController.sv ====
`include "player_cfg.svh"

module jumpController
	import player_pkg::*;
(
	input  logic         Reset,
	input  logic         frame_clk,
	input  logic         jumpTick,
	input  logic         grounded,
	input  keycodeT      keycode,
	input  keycodeT      keycodeAlt,
	input  obstacleMaskT obstacleTop,
	output velocityT     velocity
);

	jumpStateT jumpState;
	jumpStateT jumpNext;

	logic jumpKey;
	logic landing;

	// Jump accepted from either key slot
	assign jumpKey = (keycode == `KEY_JUMP) || (keycodeAlt == `KEY_JUMP);
	// Standing on ground or on top of any obstacle
	assign landing = grounded || (|obstacleTop);

	// ============================================================
	// State register
	// ============================================================
	// Steps on the jump strobe, at once when support appears
	always_ff @(posedge frame_clk or posedge Reset) begin
		if (Reset)
			jumpState <= Start;
		else if (jumpTick || landing)
			jumpState <= jumpNext;
	end

	// Next state, arc and fall run in enum order
	always_comb begin
		jumpNext = Start;
		if (jumpState == Start) begin
			if (jumpKey)
				jumpNext = Jump1;
			else if (!landing)
				// Walked off an edge
				jumpNext = Fall1;
		end else if (!landing && jumpState != Fall15) begin
			jumpNext = jumpStateT'(jumpState + 6'd1);
		end
	end

	// ============================================================
	// Velocity per state
	// ============================================================
	always_comb begin
		velocity = '0;
		if (jumpState == Start) begin
			if (jumpKey)
				velocity = -12'sd11;
			else if (!landing)
				velocity = 12'sd1;
		end else if (!landing) begin
			case (jumpState)
				// Rising, slowing toward the top
				Jump1:  velocity = -12'sd11;
				JumpA:  velocity = -12'sd10;
				Jump2:  velocity = -12'sd9;
				Jump3:  velocity = -12'sd8;
				Jump4:  velocity = -12'sd7;
				Jump5:  velocity = -12'sd6;
				Jump6:  velocity = -12'sd5;
				Jump7:  velocity = -12'sd4;
				Jump8:  velocity = -12'sd3;
				Jump9:  velocity = -12'sd2;
				Jump10: velocity = -12'sd1;
				ArcTop: velocity = 12'sd0;
				// Falling, speeding up
				Fall0:  velocity = 12'sd1;
				Fall1:  velocity = 12'sd2;
				Fall2:  velocity = 12'sd3;
				Fall3:  velocity = 12'sd4;
				Fall4:  velocity = 12'sd5;
				Fall5:  velocity = 12'sd6;
				Fall6:  velocity = 12'sd7;
				Fall7:  velocity = 12'sd8;
				Fall8:  velocity = 12'sd9;
				Fall9:  velocity = 12'sd10;
				// Terminal speed creeps up in pairs
				Fall10: velocity = 12'sd11;
				Fall11: velocity = 12'sd11;
				Fall12: velocity = 12'sd12;
				Fall13: velocity = 12'sd12;
				Fall14: velocity = 12'sd13;
				Fall15: velocity = 12'sd13;
				default: velocity = '0;
			endcase
		end
	end

	// Vertical speed bounded by the arc table
	velocityRange: assert property (@(posedge frame_clk) disable iff (Reset)
		(velocity >= -12'sd11) && (velocity <= 12'sd13))
		else $error("velocity outside jump table range");

endmodule

// ==== hdl/horizontalMover.sv ====
`include "player_cfg.svh"

module horizontalMover
	import player_pkg::*;
(
	input  logic         Reset,
	input  logic         frame_clk,
	input  logic         wideBounds,
	input  keycodeT      keycode,
	input  keycodeT      keycodeAlt,
	input  obstacleMaskT obstacleLeft,
	input  obstacleMaskT obstacleRight,
	output coordT        playerX,
	output coordT        scrollX,
	output logic         facingRight
);

	coordT   xMax;
	coordT   stepArmed;
	coordT   stepKey;
	logic    faceNext;
	logic    canLeft;
	logic    canRight;
	keycodeT keySlot [2];

	// Right limit follows screen width
	assign xMax = wideBounds ? `X_MAX_WIDE : `X_MAX_NARROW;

	// Compare, no subtract, so no wrap at the left edge
	assign canLeft = (playerX > (`X_MIN + `PLAYER_SIZE)) && (obstacleLeft == '0);
	assign canRight = ((playerX + `PLAYER_SIZE) < xMax) && (obstacleRight == '0);

	assign keySlot[0] = keycode;
	assign keySlot[1] = keycodeAlt;

	// ============================================================
	// Key decode, second slot wins
	// ============================================================
	always_comb begin
		stepKey = '0;
		faceNext = facingRight;
		for (int i = 0; i < 2; i++) begin
			if (keySlot[i] == `KEY_LEFT) begin
				stepKey = canLeft ? -`WALK_STEP : '0;
				if (canLeft)
					faceNext = 1'b0;
			end else if (keySlot[i] == `KEY_RIGHT) begin
				stepKey = canRight ? `WALK_STEP : '0;
				if (canRight)
					faceNext = 1'b1;
			end
		end
	end

	// ============================================================
	// Position, armed step and facing
	// ============================================================
	// Arm one cycle, move the next, so 3 px every 2 frames
	always_ff @(posedge frame_clk or posedge Reset) begin
		if (Reset) begin
			playerX <= `PLAYER_X_START;
			stepArmed <= '0;
			facingRight <= 1'b1;
		end else begin
			playerX <= playerX + stepArmed;
			stepArmed <= (stepArmed != '0) ? '0 : stepKey;
			facingRight <= faceNext;
		end
	end

	// Scroll while pushing right at the limit, first slot only
	always_ff @(posedge frame_clk or posedge Reset) begin
		if (Reset)
			scrollX <= '0;
		else if (((playerX + `PLAYER_SIZE) >= xMax) && (keycode == `KEY_RIGHT)
				&& (obstacleRight == '0))
			scrollX <= scrollX + `SCROLL_STEP;
	end

	// Position only ever moves by one walk step
	xStep: assert property (@(posedge frame_clk) disable iff (Reset)
		(playerX == $past(playerX)) || (playerX == $past(playerX) + `WALK_STEP)
		|| (playerX == $past(playerX) - `WALK_STEP))
		else $error("playerX moved by more than one step");

endmodule

// ==== hdl/verticalTracker.sv ====
`include "player_cfg.svh"

module verticalTracker
	import player_pkg::*;
(
	input  logic     Reset,
	input  logic     frame_clk,
	input  keycodeT  keycode,
	input  keycodeT  keycodeAlt,
	input  velocityT velocity,
	output coordT    playerY,
	output logic     grounded
);

	logic jumpKey;
	logic belowGround;

	assign jumpKey = (keycode == `KEY_JUMP) || (keycodeAlt == `KEY_JUMP);
	// Sprite bottom reached the ground line
	assign belowGround = (playerY + `PLAYER_SIZE) >= `GROUND_LINE;

	// ============================================================
	// Height integration and ground flag
	// ============================================================
	always_ff @(posedge frame_clk or posedge Reset) begin
		if (Reset) begin
			playerY <= `PLAYER_Y_START;
			grounded <= 1'b0;
		end else begin
			// Snap back to the resting line, else add velocity
			if (belowGround)
				playerY <= `PLAYER_Y_START;
			else
				playerY <= playerY + coordT'(velocity);
			// Jump key lifts off, rest line sets it again
			if (jumpKey)
				grounded <= 1'b0;
			else if (playerY == `PLAYER_Y_START)
				grounded <= 1'b1;
		end
	end

	// First frame after reset starts on the resting line
	yAfterReset: assert property (@(posedge frame_clk)
		$fell(Reset) |-> (playerY == `PLAYER_Y_START))
		else $error("playerY not at start after reset");

endmodule

// ==== hdl/playerCore.sv ====
module playerCore
	import player_pkg::*;
(
	input  logic         Reset,
	input  logic         frame_clk,
	input  keycodeT      keycode,
	input  keycodeT      keycodeAlt,
	input  logic         wideBounds,
	input  obstacleMaskT obstacleLeft,
	input  obstacleMaskT obstacleRight,
	input  obstacleMaskT obstacleTop,
	output coordT        playerX,
	output coordT        playerY,
	output coordT        scrollX,
	output logic         facingRight,
	output logic [3:0]   walkPose
);

	// Frame strobes
	logic walkTick;
	logic jumpTick;
	// Vertical loop between tracker and jump FSM
	logic     grounded;
	velocityT velocity;

	frameTicker u_frameTicker (
		.Reset(Reset),
		.frame_clk(frame_clk),
		.walkTick(walkTick),
		.jumpTick(jumpTick)
	);

	walkAnimator u_walkAnimator (
		.Reset(Reset),
		.frame_clk(frame_clk),
		.walkTick(walkTick),
		.facingRight(facingRight),
		.keycode(keycode),
		.walkPose(walkPose)
	);

	jumpController u_jumpController (
		.Reset(Reset),
		.frame_clk(frame_clk),
		.jumpTick(jumpTick),
		.grounded(grounded),
		.keycode(keycode),
		.keycodeAlt(keycodeAlt),
		.obstacleTop(obstacleTop),
		.velocity(velocity)
	);

	horizontalMover u_horizontalMover (
		.Reset(Reset),
		.frame_clk(frame_clk),
		.wideBounds(wideBounds),
		.keycode(keycode),
		.keycodeAlt(keycodeAlt),
		.obstacleLeft(obstacleLeft),
		.obstacleRight(obstacleRight),
		.playerX(playerX),
		.scrollX(scrollX),
		.facingRight(facingRight)
	);

	verticalTracker u_verticalTracker (
		.Reset(Reset),
		.frame_clk(frame_clk),
		.keycode(keycode),
		.keycodeAlt(keycodeAlt),
		.velocity(velocity),
		.playerY(playerY),
		.grounded(grounded)
	);

endmodule

// ==== bench/playerTb.sv ====
`include "player_cfg.svh"

module playerTb
	import player_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	// ============================================================
	// Run length
	// ============================================================
	// Reset, walking, blocking, three jumps, random
	localparam int PhaseCycles = 40 + 1400 + 200 + 3 * 300 + 600;
	localparam int MarginCycles = 200;
	localparam int ClockPeriod = 8;

	logic frame_clk = 1'b0;
	logic Reset;
	keycodeT keycode;
	keycodeT keycodeAlt;
	logic wideBounds;
	obstacleMaskT obstacleLeft;
	obstacleMaskT obstacleRight;
	obstacleMaskT obstacleTop;
	coordT playerX;
	coordT playerY;
	coordT scrollX;
	logic facingRight;
	logic [3:0] walkPose;

	int seed = 32'h5d8a;

	playerCore u_playerCore (
		.Reset(Reset),
		.frame_clk(frame_clk),
		.keycode(keycode),
		.keycodeAlt(keycodeAlt),
		.wideBounds(wideBounds),
		.obstacleLeft(obstacleLeft),
		.obstacleRight(obstacleRight),
		.obstacleTop(obstacleTop),
		.playerX(playerX),
		.playerY(playerY),
		.scrollX(scrollX),
		.facingRight(facingRight),
		.walkPose(walkPose)
	);

	always #(ClockPeriod / 2) frame_clk = ~frame_clk;

	task automatic reportMismatch(input string sig, input logic [31:0] got,
			input logic [31:0] want);
		$display("FAILED %s: got %h, expected %h", sig, got, want);
		$display("Something failed");
		$fatal(1, "value check");
	endtask

	task automatic reportProblem(input string what);
		$display("%s", what);
		$display("Something failed");
		$fatal(1, "run aborted");
	endtask

	// ============================================================
	// Reference terms from the movement rules
	// ============================================================
	logic jumpKeyAny;
	coordT rightLimit;
	coordT upperX;
	logic scrollCond;
	logic blockHeld;
	assign jumpKeyAny = (keycode == `KEY_JUMP) || (keycodeAlt == `KEY_JUMP);
	assign rightLimit = wideBounds ? 12'd639 : 12'd319;
	assign upperX = wideBounds ? 12'd608 : 12'd287;
	assign scrollCond = ((playerX + 12'd32) >= rightLimit) && (keycode == `KEY_RIGHT)
		&& (obstacleRight == '0);
	// Pressed direction has a contact and the second slot adds no move
	assign blockHeld = (keycodeAlt != `KEY_LEFT) && (keycodeAlt != `KEY_RIGHT)
		&& (((keycode == `KEY_LEFT) && (|obstacleLeft))
		|| ((keycode == `KEY_RIGHT) && (|obstacleRight)));

	// Previous-cycle history
	logic prevReset = 1'b1;
	coordT prevX = 12'd32;
	coordT prevY = 12'd388;
	coordT prevScroll = '0;
	logic prevScrollCond = 1'b0;
	logic prevBlock = 1'b0;
	logic prevBlockTwice = 1'b0;
	logic prevLaunch = 1'b0;
	logic prevRight = 1'b0;
	logic prevFacing = 1'b1;
	logic [3:0] prevPose = 4'h8;
	logic [3:0] lastFoot = 4'hA;
	int restCount = 0;
	int fallCount = 0;

	always @(posedge frame_clk) begin
		prevReset <= Reset;
		prevX <= playerX;
		prevY <= playerY;
		prevScroll <= scrollX;
		prevScrollCond <= scrollCond;
		prevBlock <= blockHeld;
		prevBlockTwice <= blockHeld && prevBlock;
		prevLaunch <= jumpKeyAny && (playerY == 12'd388) && (restCount >= 3);
		prevRight <= keycode == `KEY_RIGHT;
		prevFacing <= facingRight;
		prevPose <= walkPose;
		if (walkPose == 4'h9 || walkPose == 4'hA)
			lastFoot <= walkPose;
		// Consecutive cycles resting on the start line
		if (playerY != 12'd388)
			restCount <= 0;
		else if (restCount < 16)
			restCount <= restCount + 1;
		// Cycles in the air since the jump key went away
		if (Reset || jumpKeyAny || (playerY == 12'd388 && prevY == 12'd388))
			fallCount <= 0;
		else
			fallCount <= fallCount + 1;
	end

	// ============================================================
	// Checks
	// ============================================================
	// Values right after reset release
	resetX: assert property (@(posedge frame_clk) (prevReset && !Reset) -> playerX == 12'h20)
		else reportMismatch("playerX", playerX, 32'h20);
	resetY: assert property (@(posedge frame_clk) (prevReset && !Reset) -> playerY == 12'h184)
		else reportMismatch("playerY", playerY, 32'h184);
	resetScroll: assert property (@(posedge frame_clk) (prevReset && !Reset) -> scrollX == '0)
		else reportMismatch("scrollX", scrollX, 32'h0);
	resetFacing: assert property (@(posedge frame_clk) (prevReset && !Reset) -> facingRight)
		else reportMismatch("facingRight", facingRight, 32'h1);
	resetPose: assert property (@(posedge frame_clk) (prevReset && !Reset) -> walkPose == 4'h8)
		else reportMismatch("walkPose", walkPose, 32'h8);

	// Walking steps and limits
	xStep: assert property (@(posedge frame_clk) disable iff (Reset)
		(playerX == prevX) || (playerX == prevX + 12'd3) || (playerX == prevX - 12'd3))
		else reportMismatch("playerX", playerX, prevX);
	xLow: assert property (@(posedge frame_clk) disable iff (Reset) playerX >= 12'd32)
		else reportMismatch("playerX", playerX, 32'd32);
	xHigh: assert property (@(posedge frame_clk) disable iff (Reset) playerX <= upperX)
		else reportMismatch("playerX", playerX, upperX);

	// Scroll grows only while pushing right at the limit
	scrollStep: assert property (@(posedge frame_clk) disable iff (Reset)
		scrollX == (prevScrollCond ? prevScroll + 12'd3 : prevScroll))
		else reportMismatch("scrollX", scrollX, prevScrollCond ? prevScroll + 12'd3 : prevScroll);

	// Held contact allows at most the armed step
	sideBlock: assert property (@(posedge frame_clk) disable iff (Reset)
		prevBlockTwice -> playerX == prevX)
		else reportMismatch("playerX", playerX, prevX);

	// Jump launch, height limit and return to the start line
	jumpLaunch: assert property (@(posedge frame_clk) disable iff (Reset)
		prevLaunch -> playerY < 12'd388)
		else reportProblem("jump key at rest did not lift the player");
	// Arc velocities 11+11+10..1 doubled
	yHigh: assert property (@(posedge frame_clk) disable iff (Reset) playerY >= 12'd234)
		else reportMismatch("playerY", playerY, 32'd234);
	landTime: assert property (@(posedge frame_clk) disable iff (Reset) fallCount <= 80)
		else reportProblem("player did not return to the start line after the jump");

	// Walk pose order with right held
	poseFirst: assert property (@(posedge frame_clk) disable iff (Reset)
		(prevRight && prevPose == 4'h9) -> (walkPose == 4'h9 || walkPose == 4'hC))
		else reportMismatch("walkPose", walkPose, 32'hC);
	poseSecond: assert property (@(posedge frame_clk) disable iff (Reset)
		(prevRight && prevPose == 4'hA) -> (walkPose == 4'hA || walkPose == 4'hC))
		else reportMismatch("walkPose", walkPose, 32'hC);
	poseSwitch: assert property (@(posedge frame_clk) disable iff (Reset)
		(prevRight && prevPose == 4'hC) -> (walkPose == 4'hC
		|| walkPose == ((lastFoot == 4'h9) ? 4'hA : 4'h9)))
		else reportMismatch("walkPose", walkPose, (lastFoot == 4'h9) ? 32'hA : 32'h9);
	poseStart: assert property (@(posedge frame_clk) disable iff (Reset)
		(prevRight && prevFacing && prevPose == 4'h8) -> (walkPose == 4'h8
		|| walkPose == 4'h9 || walkPose == {facingRight, 3'b000}))
		else reportMismatch("walkPose", walkPose, 32'h9);
	// Releasing right falls back to idle
	poseIdle: assert property (@(posedge frame_clk) disable iff (Reset)
		(!prevRight && (prevPose == 4'h9 || prevPose == 4'hA || prevPose == 4'hC))
		-> (walkPose == prevPose || walkPose == {facingRight, 3'b000}))
		else reportMismatch("walkPose", walkPose, {facingRight, 3'b000});

	// ============================================================
	// Stimulus
	// ============================================================
	task automatic cycles(input int n);
		repeat (n) @(posedge frame_clk);
	endtask

	// Hold one key until playerX hits the target
	task automatic walkUntil(input keycodeT key, input coordT target, input int limit);
		int n;
		n = 0;
		@(posedge frame_clk);
		keycode <= key;
		while (playerX != target) begin
			if (n >= limit)
				reportProblem("player did not reach the expected position");
			@(posedge frame_clk);
			n++;
		end
		keycode <= '0;
	endtask

	task automatic waitRest(input int limit);
		int n;
		n = 0;
		while (restCount < 4) begin
			if (n >= limit)
				reportProblem("player never came to rest");
			@(posedge frame_clk);
			n++;
		end
	endtask

	task automatic jumpOnce();
		waitRest(300);
		@(posedge frame_clk);
		keycode <= `KEY_JUMP;
		cycles(4);
		keycode <= '0;
		waitRest(300);
	endtask

	function automatic keycodeT pickKey(input logic [2:0] sel, input keycodeT other);
		case (sel)
			3'd1, 3'd4: pickKey = `KEY_LEFT;
			3'd2, 3'd3: pickKey = `KEY_RIGHT;
			3'd5:       pickKey = `KEY_JUMP;
			3'd6:       pickKey = other;
			default:    pickKey = '0;
		endcase
	endfunction

	// Watchdog
	initial begin
		#((PhaseCycles + MarginCycles) * ClockPeriod);
		$display("timeout, the test sequence did not finish in time");
		$display("Something failed");
		$fatal(1, "watchdog");
	end

	initial begin
		logic [31:0] r;
		logic [31:0] s;
		obstacleMaskT mask;
		Reset = 1'b1;
		keycode = '0;
		keycodeAlt = '0;
		wideBounds = 1'b0;
		obstacleLeft = '0;
		obstacleRight = '0;
		obstacleTop = '0;
		cycles(2);
		Reset <= 1'b0;
		cycles(40);

		// Narrow then wide screen, out and back
		walkUntil(`KEY_RIGHT, 12'd287, 400);
		// Keep pushing at the right limit so the screen scrolls
		@(posedge frame_clk);
		keycode <= `KEY_RIGHT;
		cycles(30);
		keycode <= '0;
		walkUntil(`KEY_LEFT, 12'd32, 400);
		wideBounds <= 1'b1;
		walkUntil(`KEY_RIGHT, 12'd608, 800);
		walkUntil(`KEY_LEFT, 12'd32, 800);
		wideBounds <= 1'b0;

		// Side contacts against a held key
		walkUntil(`KEY_RIGHT, 12'd101, 200);
		mask = obstacleMaskT'($random(seed));
		if (mask == '0)
			mask = 1;
		keycode <= `KEY_RIGHT;
		obstacleRight <= mask;
		cycles(40);
		obstacleRight <= '0;
		keycode <= `KEY_LEFT;
		obstacleLeft <= mask;
		cycles(40);
		obstacleLeft <= '0;
		keycode <= '0;

		repeat (3) jumpOnce();

		// Random keys and side contacts
		repeat (600) begin
			@(posedge frame_clk);
			r = $random(seed);
			s = $random(seed);
			keycode <= pickKey(r[2:0], r[15:8]);
			keycodeAlt <= pickKey(r[5:3], r[23:16]);
			obstacleLeft <= (s[2:0] == 3'd0) ? obstacleMaskT'(s[15:8]) : '0;
			obstacleRight <= (s[5:3] == 3'd0) ? obstacleMaskT'(s[23:16]) : '0;
		end
		@(posedge frame_clk);
		keycode <= '0;
		keycodeAlt <= '0;
		obstacleLeft <= '0;
		obstacleRight <= '0;
		cycles(5);
		$display("Everything OK");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+hdl
hdl/player_pkg.sv
hdl/frameTicker.sv
hdl/walkAnimator.sv
hdl/jumpController.sv
hdl/horizontalMover.sv
hdl/verticalTracker.sv
hdl/playerCore.sv
bench/playerTb.sv

// ==== Makefile ====
# Verilator build and run for the player motion core

VERILATOR ?= verilator
TOP ?= playerTb
RTL_TOP ?= playerCore
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS ?= --timing --assert --timescale $(TIMESCALE)

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
